// File: compile.f
hdl/arch_pkg.sv
hdl/sys_ctrl_pkg.sv
hdl/int_latch.sv
hdl/int_service.sv
hdl/ret_sequencer.sv
hdl/sys_ctrl_top.sv
tests/sys_ctrl_tb.sv

// File: hdl/arch_pkg.sv
`default_nettype none

package arch_pkg;

  ////////////////////////////////////////////////////////////
  // architectural widths

  // linear address and memory data word
  localparam int addr_w = 32;

  // code segment selector
  localparam int seg_w = 16;

  ////////////////////////////////////////////////////////////
  // register value types

  // eflags, eip, addresses and memory data
  typedef logic [addr_w-1:0] word_t;

  // cs selector value
  typedef logic [seg_w-1:0] seg_t;

endpackage

`default_nettype wire

// File: hdl/int_latch.sv
`timescale 1ns/1ps
`default_nettype none

module int_latch (
  input  wire                   clk,
  input  wire                   reset,
  input  sys_ctrl_pkg::int_vec_t int_vec,
  input  wire                   int_clear,
  output logic                  pending,
  output sys_ctrl_pkg::int_idx_t serviced_idx
);

  sys_ctrl_pkg::int_vec_t pend_q;
  sys_ctrl_pkg::int_vec_t clear_mask;
  sys_ctrl_pkg::int_vec_t pend_d;

  // one-hot mask of the bit being retired
  always_comb begin
    clear_mask = '0;
    if (int_clear) begin
      clear_mask[serviced_idx] = 1'b1;
    end
  end

  // new lines merge with held ones, the serviced bit drops out
  assign pend_d = (int_vec | pend_q) & ~clear_mask;

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_d;
    end
  end

  assign pending = |pend_q;

  // lowest numbered pending line wins
  always_comb begin
    serviced_idx = '0;
    for (int i = sys_ctrl_pkg::num_int - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        serviced_idx = sys_ctrl_pkg::int_idx_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/int_service.sv
`timescale 1ns/1ps
`default_nettype none

module int_service (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    pending,
  input  sys_ctrl_pkg::int_idx_t serviced_idx,
  input  wire                    hold_int,
  input  wire                    ret_busy,

  output logic                   mem_valid,
  input  wire                    mem_ready,
  output arch_pkg::word_t        mem_address,
  output logic                   mem_wr_en,
  output arch_pkg::word_t        mem_wr_data,
  output logic [3:0]             mem_wr_size,
  input  wire                    mem_dp_valid,
  output logic                   mem_dp_ready,
  input  arch_pkg::word_t        mem_dp_read_data,

  output logic                   flush_fetch,
  output logic                   flush_decode_0,
  output logic                   flush_decode_1,
  output logic                   flush_register,
  output logic                   flush_address,
  output logic                   flush_execute,
  output logic                   flush_writeback,

  output logic                   decode_start_int,
  input  wire                    decode_end_int,

  output logic                   fetch_load,
  output arch_pkg::word_t        fetch_load_address,
  output logic                   int_clear,
  output logic                   int_busy
);

  sys_ctrl_pkg::svc_state_t state;
  sys_ctrl_pkg::svc_state_t next_state;
  sys_ctrl_pkg::int_idx_t   idx_q;
  arch_pkg::word_t          handler_q;
  logic                     start_pulse;
  logic                     can_start;

  assign can_start = pending & ~hold_int & ~ret_busy;

  ////////////////////////////////////////////////////////////
  // state sequencing

  always_comb begin
    next_state = state;
    case (state)
      sys_ctrl_pkg::svc_idle:
        if (can_start) next_state = sys_ctrl_pkg::svc_read;
      sys_ctrl_pkg::svc_read:
        if (mem_ready) next_state = sys_ctrl_pkg::svc_wait_data;
      sys_ctrl_pkg::svc_wait_data:
        if (mem_dp_valid) next_state = sys_ctrl_pkg::svc_decode;
      sys_ctrl_pkg::svc_decode:
        if (decode_end_int) next_state = sys_ctrl_pkg::svc_load;
      sys_ctrl_pkg::svc_load:
        next_state = sys_ctrl_pkg::svc_idle;
      default:
        next_state = sys_ctrl_pkg::svc_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= sys_ctrl_pkg::svc_idle;
      start_pulse <= 1'b0;
    end else begin
      state       <= next_state;
      // one cycle on entry to decode
      start_pulse <= (state == sys_ctrl_pkg::svc_wait_data) & mem_dp_valid;
    end
  end

  // index frozen at start so a later line cannot redirect the read
  always_ff @(posedge clk) begin
    if (state == sys_ctrl_pkg::svc_idle && can_start) begin
      idx_q <= serviced_idx;
    end
    if (state == sys_ctrl_pkg::svc_wait_data && mem_dp_valid) begin
      handler_q <= mem_dp_read_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs

  assign mem_valid    = (state == sys_ctrl_pkg::svc_read);
  assign mem_address  = sys_ctrl_pkg::idt_addr[idx_q];
  assign mem_wr_en    = 1'b0;
  assign mem_wr_data  = '0;
  assign mem_wr_size  = 4'd4;
  assign mem_dp_ready = (state == sys_ctrl_pkg::svc_wait_data);

  // whole pipe is flushed together with the micro-sequence kick
  assign flush_fetch      = start_pulse;
  assign flush_decode_0   = start_pulse;
  assign flush_decode_1   = start_pulse;
  assign flush_register   = start_pulse;
  assign flush_address    = start_pulse;
  assign flush_execute    = start_pulse;
  assign flush_writeback  = start_pulse;
  assign decode_start_int = start_pulse;

  assign fetch_load         = (state == sys_ctrl_pkg::svc_load);
  assign fetch_load_address = handler_q;
  assign int_clear          = (state == sys_ctrl_pkg::svc_load);
  assign int_busy           = (state != sys_ctrl_pkg::svc_idle);

endmodule

`default_nettype wire

// File: hdl/ret_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ret_sequencer (
  input  wire             clk,
  input  wire             reset,
  input  wire             iretd,
  input  wire             ret_far,
  input  wire             ret_near,
  input  wire             int_busy,
  input  arch_pkg::seg_t  cs_register,

  input  wire             iretd_pop_valid,
  input  arch_pkg::word_t iretd_pop_data,

  output logic            reg_load_eflags,
  output arch_pkg::word_t reg_eflags,
  output logic            reg_load_cs,
  output arch_pkg::seg_t  reg_cs,
  output logic            reg_load_eip,
  output arch_pkg::word_t reg_eip,

  output logic            fetch_load,
  output arch_pkg::word_t fetch_load_address,
  output logic            iretd_halt,
  output logic            ret_busy
);

  sys_ctrl_pkg::ret_state_t state;
  sys_ctrl_pkg::ret_state_t next_state;
  arch_pkg::seg_t           cs_tmp;
  arch_pkg::seg_t           used_cs;
  logic                     near_q;
  logic                     start;

  assign start = (state == sys_ctrl_pkg::ret_idle) & ~int_busy & (iretd | ret_far | ret_near);

  ////////////////////////////////////////////////////////////
  // pop sequencing

  always_comb begin
    next_state = state;
    case (state)
      sys_ctrl_pkg::ret_idle: begin
        // the return kind picks how many words get popped
        if (!int_busy) begin
          if (iretd) next_state = sys_ctrl_pkg::ret_pop_eflags;
          else if (ret_far) next_state = sys_ctrl_pkg::ret_pop_cs;
          else if (ret_near) next_state = sys_ctrl_pkg::ret_pop_eip;
        end
      end
      sys_ctrl_pkg::ret_pop_eflags:
        if (iretd_pop_valid) next_state = sys_ctrl_pkg::ret_pop_cs;
      sys_ctrl_pkg::ret_pop_cs:
        if (iretd_pop_valid) next_state = sys_ctrl_pkg::ret_pop_eip;
      sys_ctrl_pkg::ret_pop_eip:
        if (iretd_pop_valid) next_state = sys_ctrl_pkg::ret_idle;
      default:
        next_state = sys_ctrl_pkg::ret_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= sys_ctrl_pkg::ret_idle;
      near_q <= 1'b0;
    end else begin
      state <= next_state;
      if (start) begin
        near_q <= ~iretd & ~ret_far;
      end
    end
  end

  // popped selector held until the eip word arrives
  always_ff @(posedge clk) begin
    if (reg_load_cs) begin
      cs_tmp <= iretd_pop_data[arch_pkg::seg_w-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // register and fetch loads

  assign reg_load_eflags = (state == sys_ctrl_pkg::ret_pop_eflags) & iretd_pop_valid;
  assign reg_load_cs     = (state == sys_ctrl_pkg::ret_pop_cs) & iretd_pop_valid;
  assign reg_load_eip    = (state == sys_ctrl_pkg::ret_pop_eip) & iretd_pop_valid;

  assign reg_eflags = iretd_pop_data;
  assign reg_cs     = iretd_pop_data[arch_pkg::seg_w-1:0];
  assign reg_eip    = iretd_pop_data;

  // near return stays in the current code segment
  assign used_cs = near_q ? cs_register : cs_tmp;

  assign fetch_load = reg_load_eip;
  assign fetch_load_address =
    {{(arch_pkg::addr_w - arch_pkg::seg_w){1'b0}}, used_cs} + iretd_pop_data;

  assign ret_busy   = (state != sys_ctrl_pkg::ret_idle);
  assign iretd_halt = ret_busy;

endmodule

`default_nettype wire

// File: hdl/sys_ctrl_pkg.sv
`default_nettype none

package sys_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // interrupt lines

  localparam int num_int = 4;

  // index of the line being serviced
  typedef logic [1:0] int_idx_t;

  // one bit per interrupt line
  typedef logic [num_int-1:0] int_vec_t;

  // fixed descriptor addresses, one per line
  localparam arch_pkg::word_t idt_addr [0:num_int-1] = '{
    32'h0000_4000,
    32'h0000_8000,
    32'h0000_c000,
    32'h0000_f000
  };

  ////////////////////////////////////////////////////////////
  // sequencer states

  typedef enum logic [2:0] {
    svc_idle      = 3'd0,
    svc_read      = 3'd1,
    svc_wait_data = 3'd2,
    svc_decode    = 3'd3,
    svc_load      = 3'd4
  } svc_state_t;

  typedef enum logic [1:0] {
    ret_idle       = 2'd0,
    ret_pop_eflags = 2'd1,
    ret_pop_cs     = 2'd2,
    ret_pop_eip    = 2'd3
  } ret_state_t;

endpackage

`default_nettype wire

// File: hdl/sys_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl_top (
  input  wire                    clk,
  input  wire                    reset,
  input  sys_ctrl_pkg::int_vec_t int_vec,
  input  arch_pkg::seg_t         cs_register,
  input  wire                    hold_int,

  output logic                   mem_valid,
  input  wire                    mem_ready,
  output arch_pkg::word_t        mem_address,
  output logic                   mem_wr_en,
  output arch_pkg::word_t        mem_wr_data,
  output logic [3:0]             mem_wr_size,
  input  wire                    mem_dp_valid,
  output logic                   mem_dp_ready,
  input  arch_pkg::word_t        mem_dp_read_data,

  output logic                   flush_fetch,
  output logic                   flush_decode_0,
  output logic                   flush_decode_1,
  output logic                   flush_register,
  output logic                   flush_address,
  output logic                   flush_execute,
  output logic                   flush_writeback,

  output logic                   fetch_load,
  output arch_pkg::word_t        fetch_load_address,
  output logic                   decode_start_int,
  input  wire                    decode_end_int,

  output logic                   reg_load_cs,
  output arch_pkg::seg_t         reg_cs,
  input  wire                    ret_near,
  input  wire                    ret_far,
  input  wire                    iretd,
  output logic                   iretd_halt,
  input  wire                    iretd_pop_valid,
  input  arch_pkg::word_t        iretd_pop_data,
  output logic                   reg_load_eflags,
  output arch_pkg::word_t        reg_eflags,
  output logic                   reg_load_eip,
  output arch_pkg::word_t        reg_eip,
  output logic                   pending_int
);

  logic                   pending;
  sys_ctrl_pkg::int_idx_t serviced_idx;
  logic                   int_clear;
  logic                   int_busy;
  logic                   ret_busy;

  logic                   svc_flush_fetch;
  logic                   svc_flush_decode_0;
  logic                   svc_flush_decode_1;
  logic                   svc_flush_register;
  logic                   svc_flush_address;
  logic                   svc_flush_execute;
  logic                   svc_flush_writeback;
  logic                   svc_fetch_load;
  arch_pkg::word_t        svc_fetch_address;
  logic                   ret_fetch_load;
  arch_pkg::word_t        ret_fetch_address;

  ////////////////////////////////////////////////////////////
  // interrupt path

  int_latch u_int_latch (
    .clk          (clk),
    .reset        (reset),
    .int_vec      (int_vec),
    .int_clear    (int_clear),
    .pending      (pending),
    .serviced_idx (serviced_idx)
  );

  int_service u_int_service (
    .clk                (clk),
    .reset              (reset),
    .pending            (pending),
    .serviced_idx       (serviced_idx),
    .hold_int           (hold_int),
    .ret_busy           (ret_busy),
    .mem_valid          (mem_valid),
    .mem_ready          (mem_ready),
    .mem_address        (mem_address),
    .mem_wr_en          (mem_wr_en),
    .mem_wr_data        (mem_wr_data),
    .mem_wr_size        (mem_wr_size),
    .mem_dp_valid       (mem_dp_valid),
    .mem_dp_ready       (mem_dp_ready),
    .mem_dp_read_data   (mem_dp_read_data),
    .flush_fetch        (svc_flush_fetch),
    .flush_decode_0     (svc_flush_decode_0),
    .flush_decode_1     (svc_flush_decode_1),
    .flush_register     (svc_flush_register),
    .flush_address      (svc_flush_address),
    .flush_execute      (svc_flush_execute),
    .flush_writeback    (svc_flush_writeback),
    .decode_start_int   (decode_start_int),
    .decode_end_int     (decode_end_int),
    .fetch_load         (svc_fetch_load),
    .fetch_load_address (svc_fetch_address),
    .int_clear          (int_clear),
    .int_busy           (int_busy)
  );

  ////////////////////////////////////////////////////////////
  // return path

  ret_sequencer u_ret_sequencer (
    .clk                (clk),
    .reset              (reset),
    .iretd              (iretd),
    .ret_far            (ret_far),
    .ret_near           (ret_near),
    .int_busy           (int_busy),
    .cs_register        (cs_register),
    .iretd_pop_valid    (iretd_pop_valid),
    .iretd_pop_data     (iretd_pop_data),
    .reg_load_eflags    (reg_load_eflags),
    .reg_eflags         (reg_eflags),
    .reg_load_cs        (reg_load_cs),
    .reg_cs             (reg_cs),
    .reg_load_eip       (reg_load_eip),
    .reg_eip            (reg_eip),
    .fetch_load         (ret_fetch_load),
    .fetch_load_address (ret_fetch_address),
    .iretd_halt         (iretd_halt),
    .ret_busy           (ret_busy)
  );

  ////////////////////////////////////////////////////////////
  // merge onto the front end controls

  // only fetch is flushed by a return, for as long as it runs
  assign flush_fetch     = svc_flush_fetch | ret_busy;
  assign flush_decode_0  = svc_flush_decode_0;
  assign flush_decode_1  = svc_flush_decode_1;
  assign flush_register  = svc_flush_register;
  assign flush_address   = svc_flush_address;
  assign flush_execute   = svc_flush_execute;
  assign flush_writeback = svc_flush_writeback;

  assign fetch_load         = svc_fetch_load | ret_fetch_load;
  assign fetch_load_address = int_busy ? svc_fetch_address : ret_fetch_address;

  assign pending_int = pending;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
  --top-module sys_ctrl_tb || exit 1

sim_out=$(./obj_dir/Vsys_ctrl_tb)
echo "$sim_out"

echo "$sim_out" | grep -qx "Test OK" && exit 0 || exit 1

// File: tests/sys_ctrl_stimulus.txt
// columns (hex): op arg hold w0 w1 w2 e0 e1 e2 rnd
// op 1 int: arg lines, w0 handler, e0 line, e1 fetch target, e2 pending after
// op 2 ret_near 3 ret_far 4 iretd: arg cs_register, w pops, e0 target, e1 cs, e2 eflags

// two lines raised, lowest first
1 0000000a 0 10001111 0 0 1 10001111 1 0
1 00000000 0 20003333 0 0 3 20003333 0 0

// service waits for hold_int to drop
1 00000005 1 30000040 0 0 0 30000040 1 0
1 00000000 0 30000080 0 0 2 30000080 0 0
1 00000008 0 00007ffc 0 0 3 00007ffc 0 0

// iretd ignores cs_register
4 00001234 0 00000202 abcd0010 00001000 00001010 00000010 00000202 0
3 00000008 0 0000f000 00000123 0 0000f123 0000f000 0 0
2 00000100 0 00002000 0 0 00002100 0 0 0

// target wraps at 32 bits
4 00000000 0 00000046 0001ffff ffff0002 00000001 0000ffff 00000046 0

// same cases with random memory and stack gaps
1 0000000a 0 10001111 0 0 1 10001111 1 1
1 00000000 0 20003333 0 0 3 20003333 0 1
4 00001234 0 00000202 abcd0010 00001000 00001010 00000010 00000202 1
3 00000008 0 0000f000 00000123 0 0000f123 0000f000 0 1
2 00000100 0 00002000 0 0 00002100 0 0 1
1 00000006 1 40000000 0 0 1 40000000 1 1
1 00000000 0 40000004 0 0 2 40000004 0 1

// File: tests/sys_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl_tb;

  localparam int clk_period = 40;
  localparam int fields = 10;
  localparam int max_tests = 32;
  localparam int decode_delay = 2;

  logic                   clk;
  logic                   reset;
  sys_ctrl_pkg::int_vec_t int_vec;
  arch_pkg::seg_t         cs_register;
  logic                   hold_int;
  logic                   mem_valid;
  logic                   mem_ready;
  arch_pkg::word_t        mem_address;
  logic                   mem_wr_en;
  arch_pkg::word_t        mem_wr_data;
  logic [3:0]             mem_wr_size;
  logic                   mem_dp_valid;
  logic                   mem_dp_ready;
  arch_pkg::word_t        mem_dp_read_data;
  logic                   flush_fetch;
  logic                   flush_decode_0;
  logic                   flush_decode_1;
  logic                   flush_register;
  logic                   flush_address;
  logic                   flush_execute;
  logic                   flush_writeback;
  logic                   fetch_load;
  arch_pkg::word_t        fetch_load_address;
  logic                   decode_start_int;
  logic                   decode_end_int;
  logic                   reg_load_cs;
  arch_pkg::seg_t         reg_cs;
  logic                   ret_near;
  logic                   ret_far;
  logic                   iretd;
  logic                   iretd_halt;
  logic                   iretd_pop_valid;
  arch_pkg::word_t        iretd_pop_data;
  logic                   reg_load_eflags;
  arch_pkg::word_t        reg_eflags;
  logic                   reg_load_eip;
  arch_pkg::word_t        reg_eip;
  logic                   pending_int;

  // one row of the stimulus file per test
  logic [31:0]     stim [0:fields*max_tests-1];
  logic [31:0]     f_op;
  logic [31:0]     f_arg;
  logic [31:0]     f_hold;
  logic [31:0]     f_rnd;
  logic [31:0]     f_w [0:2];
  logic [31:0]     f_e [0:2];
  int              num_tests = 0;
  int              error_count = 0;
  int              test_errors;
  int              pass_count = 0;
  int              fail_count = 0;
  int              starts_seen;
  int              end_count;
  int              mem_gap_req;
  int              mem_gap_data;
  int              pop_gap [0:2];
  arch_pkg::word_t cur_handler;
  arch_pkg::word_t cap_addr;
  logic            cap_wr_en;
  arch_pkg::word_t cap_wr_data;
  logic [3:0]      cap_wr_size;
  logic            cap_dp_ready;
  logic [7:0]      load_seq;

  sys_ctrl_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Error %s: got %h expected %h", name, got, expected);
      error_count++;
      test_errors++;
    end
  endtask

  function automatic int draw_gap();
    if (f_rnd != 32'd0) begin
      return int'($urandom % 4);
    end
    return 0;
  endfunction

  function automatic string op_name(input logic [31:0] op);
    case (op)
      32'd1: return "int";
      32'd2: return "ret_near";
      32'd3: return "ret_far";
      default: return "iretd";
    endcase
  endfunction

  task automatic load_test(input int t);
    int base;
    base = t * fields;
    f_op = stim[base];
    f_arg = stim[base+1];
    f_hold = stim[base+2];
    for (int k = 0; k < 3; k++) begin
      f_w[k] = stim[base+3+k];
      f_e[k] = stim[base+6+k];
    end
    f_rnd = stim[base+9];
  endtask

  // all seven flushes go with the decode kick and never alone
  task automatic scan_flushes();
    logic [6:0] flushes;
    flushes = {flush_fetch, flush_decode_0, flush_decode_1, flush_register,
               flush_address, flush_execute, flush_writeback};
    if (decode_start_int) begin
      starts_seen++;
      check_value("flush outputs", 32'(flushes), 32'h7f);
    end else begin
      check_value("flush outputs", 32'(flushes), 32'h00);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory, decoder and stack models

  initial begin : memory_model
    mem_ready = 1'b0;
    mem_dp_valid = 1'b0;
    mem_dp_read_data = '0;
    forever begin
      @(posedge clk);
      #2;
      if (mem_valid === 1'b1) begin
        repeat (mem_gap_req) begin
          @(posedge clk);
          #2;
        end
        mem_ready = 1'b1;
        cap_addr = mem_address;
        cap_wr_en = mem_wr_en;
        cap_wr_data = mem_wr_data;
        cap_wr_size = mem_wr_size;
        @(posedge clk);
        #2;
        mem_ready = 1'b0;
        repeat (mem_gap_data) begin
          @(posedge clk);
          #2;
        end
        mem_dp_valid = 1'b1;
        mem_dp_read_data = cur_handler;
        cap_dp_ready = mem_dp_ready;
        @(posedge clk);
        #2;
        mem_dp_valid = 1'b0;
        mem_dp_read_data = '0;
      end
    end
  end

  initial begin : decoder_model
    decode_end_int = 1'b0;
    end_count = 0;
    forever begin
      @(posedge clk);
      #2;
      if (decode_start_int === 1'b1) begin
        repeat (decode_delay) begin
          @(posedge clk);
          #2;
        end
        decode_end_int = 1'b1;
        end_count++;
        @(posedge clk);
        #2;
        decode_end_int = 1'b0;
      end
    end
  end

  task automatic present_pops(input int n);
    for (int k = 0; k < n; k++) begin
      repeat (pop_gap[k]) begin
        @(posedge clk);
        #2;
      end
      iretd_pop_valid = 1'b1;
      iretd_pop_data = f_w[k];
      @(posedge clk);
      #2;
      iretd_pop_valid = 1'b0;
      iretd_pop_data = '0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test bodies

  task automatic run_int_test();
    int end_base;
    end_base = end_count;
    starts_seen = 0;
    cur_handler = f_w[0];
    mem_gap_req = draw_gap();
    mem_gap_data = draw_gap();
    @(posedge clk);
    #2;
    int_vec = f_arg[3:0];
    @(posedge clk);
    #2;
    int_vec = '0;
    if (f_hold != 32'd0) begin
      repeat (4) begin
        @(negedge clk);
        check_value("mem_valid", 32'(mem_valid), 32'd0);
      end
      check_value("pending_int", 32'(pending_int), 32'd1);
      @(posedge clk);
      #2;
    end
    hold_int = 1'b0;
    @(negedge clk);
    while (!fetch_load) begin
      scan_flushes();
      @(negedge clk);
    end
    scan_flushes();
    check_value("fetch_load_address", fetch_load_address, f_e[1]);
    check_value("mem_address", cap_addr, sys_ctrl_pkg::idt_addr[f_e[0][1:0]]);
    check_value("mem_wr_en", 32'(cap_wr_en), 32'd0);
    check_value("mem_wr_data", cap_wr_data, 32'd0);
    check_value("mem_wr_size", 32'(cap_wr_size), 32'(arch_pkg::addr_w / 8));
    check_value("mem_dp_ready", 32'(cap_dp_ready), 32'd1);
    check_value("decode_start_int pulses", 32'(starts_seen), 32'd1);
    check_value("decode_end_int pulses", 32'(end_count - end_base), 32'd1);
    check_value("pending_int", 32'(pending_int), 32'd1);
    @(posedge clk);
    #2;
    hold_int = 1'b1;
    @(negedge clk);
    check_value("pending_int", 32'(pending_int), f_e[2]);
  endtask

  task automatic watch_return(input arch_pkg::word_t eip_exp);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      check_value("iretd_halt", 32'(iretd_halt), 32'd1);
      check_value("flush outputs", 32'({flush_fetch, flush_decode_0, flush_decode_1,
        flush_register, flush_address, flush_execute, flush_writeback}), 32'h40);
      if (reg_load_eflags) begin
        load_seq = {load_seq[5:0], 2'd1};
        check_value("reg_eflags", reg_eflags, f_e[2]);
      end
      if (reg_load_cs) begin
        load_seq = {load_seq[5:0], 2'd2};
        check_value("reg_cs", 32'(reg_cs), f_e[1]);
      end
      if (reg_load_eip) begin
        load_seq = {load_seq[5:0], 2'd3};
        check_value("reg_eip", reg_eip, eip_exp);
      end
      if (fetch_load) begin
        check_value("fetch_load_address", fetch_load_address, f_e[0]);
        done = 1'b1;
      end
    end
  endtask

  task automatic run_ret_test();
    int         n_pops;
    logic [7:0] exp_seq;
    // near pops eip, far adds cs, iretd adds eflags
    n_pops = int'(f_op) - 1;
    exp_seq = (n_pops == 3) ? 8'h1b : (n_pops == 2) ? 8'h0b : 8'h03;
    for (int k = 0; k < 3; k++) begin
      pop_gap[k] = draw_gap();
    end
    load_seq = 8'h00;
    @(posedge clk);
    #2;
    cs_register = f_arg[15:0];
    iretd = (f_op == 32'd4);
    ret_far = (f_op == 32'd3);
    ret_near = (f_op == 32'd2);
    @(posedge clk);
    #2;
    iretd = 1'b0;
    ret_far = 1'b0;
    ret_near = 1'b0;
    fork
      present_pops(n_pops);
      watch_return(f_w[n_pops-1]);
    join
    @(negedge clk);
    check_value("iretd_halt", 32'(iretd_halt), 32'd0);
    check_value("flush_fetch", 32'(flush_fetch), 32'd0);
    check_value("load order", 32'(load_seq), 32'(exp_seq));
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin : main
    void'($urandom(32'h7dba_d5a4));
    reset = 1'b1;
    int_vec = '0;
    cs_register = '0;
    hold_int = 1'b1;
    ret_near = 1'b0;
    ret_far = 1'b0;
    iretd = 1'b0;
    iretd_pop_valid = 1'b0;
    iretd_pop_data = '0;
    cur_handler = '0;
    f_rnd = '0;
    for (int i = 0; i < fields * max_tests; i++) begin
      stim[i] = '0;
    end
    $readmemh("tests/sys_ctrl_stimulus.txt", stim);
    while (num_tests < max_tests && stim[num_tests * fields] != 32'd0) begin
      num_tests++;
    end
    if (num_tests == 0) begin
      $display("no tests were found in the stimulus file");
    end
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      load_test(t);
      test_errors = 0;
      if (f_op == 32'd1) begin
        run_int_test();
      end else begin
        run_ret_test();
      end
      if (test_errors == 0) begin
        pass_count++;
        $display("test %0d %s: ok", t + 1, op_name(f_op));
      end else begin
        fail_count++;
        $display("test %0d %s: failed with %0d errors", t + 1, op_name(f_op), test_errors);
      end
    end
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0 && num_tests > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // budget of 200 clocks per test
  initial begin : watchdog
    wait (num_tests > 0);
    #(num_tests * 200 * clk_period);
    $display("timeout: the DUT stopped answering before all tests finished");
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
